/* build.f */
+incdir+test
source/cpu_bus_pkg.sv
source/cpu_isa_pkg.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_bus_unit.sv
source/cpu_control.sv
source/cpu_top.sv
test/tb_cpu.sv

/* test/tb_cpu_tests.svh */
task automatic check_half(string what, half_t got, half_t exp);
    if (got !== exp) begin
        $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_addr(string what, addr_t got, addr_t exp);
    if (got !== exp) begin
        $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_ccr(string what, ccr_t got, ccr_t exp);
    if (got !== exp) begin
        $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp);
        errors++;
    end
endtask

task automatic begin_test(string name);
    test_name = name;
    test_base = errors;
endtask

task automatic end_test();
    tests_run++;
    if (errors == test_base) begin
        $display("%s: pass", test_name);
    end else begin
        tests_failed++;
        $display("%s: fail, %0d errors", test_name, errors - test_base);
    end
endtask

// logged writes against exp_wa and exp_wd in order
task automatic check_writes();
    int n;
    n = 0;
    foreach (xa[i]) begin
        if (xw[i]) begin
            if (n < exp_wa.size()) begin
                check_addr("write address", xa[i], exp_wa[n]);
                check_half("write data", xd[i], exp_wd[n]);
            end
            n++;
        end
    end
    if (n != exp_wa.size()) begin
        $display("%0d ns: saw %0d halfword writes where %0d were expected",
                 $time, n, exp_wa.size());
        errors++;
    end
endtask

task automatic test_reset_fetch();
    begin_test("reset and fetch");
    reset_dut(1'b1);
    repeat (4) emit_inh(op_nop, 0, 0);
    put(bad_insn);
    wait_halt();
    if (xa.size() != 5) begin
        $display("%0d ns: saw %0d fetches where 5 were expected", $time, xa.size());
        errors++;
    end
    foreach (xa[i]) begin
        check_addr("fetch address", xa[i], addr_t'(2 * i));
        check_half("fetch write flag", half_t'(xw[i]), 16'h0000);
    end
    end_test();
endtask

task automatic test_alu_ops();
    begin_test("alu operations");
    reset_dut(1'b0);
    build_alu_program();
    wait_halt();
    check_writes();
    end_test();
endtask

task automatic test_cmp_branch();
    word_t pa [6];
    word_t pb [6];
    pa = '{32'd5, 32'd3, 32'd7, 32'h8000_0000, 32'd1, 32'hffff_ffff};
    pb = '{32'd5, 32'd7, 32'd3, 32'd1, 32'h8000_0000, 32'd0};
    begin_test("cmp and branches");
    for (int p = 0; p < 6; p++) begin
        reset_dut(1'b1);
        emit_imm2(op_ldis, 1, 16'h1000);
        emit_imm2(op_ldis, 6, 16'h5a00);  // marker value
        emit_ldi(2, pa[p]);
        emit_ldi(3, pb[p]);
        emit_inh(op_cmp, 3, 2);
        for (int i = 0; i < 12; i++) begin
            emit_imm2(opcode_t'(i), 0, 16'd4);  // skips the st below
            emit_regind(op_st, 1, 6, 11'(2 * i));
            if (!branch_expect(opcode_t'(i), pa[p], pb[p])) begin
                exp_wa.push_back(addr_t'(32'h1000 + 2 * i));
                exp_wd.push_back(16'h5a00);
            end
        end
        put(bad_insn);
        wait_halt();
        check_ccr("ccr after cmp", ccr, sub_flags(pa[p], pb[p]));
        check_writes();
    end
    end_test();
endtask

task automatic test_loads();
    half_t d0;
    half_t d1;
    half_t d2;
    begin_test("loads and lda");
    reset_dut(1'b1);
    d0 = 16'hbeef;
    d1 = 16'h1234;
    d2 = 16'hcafe;
    mem[12'hc00] = d0;  // byte address 1800
    mem[12'hc01] = d1;
    mem[12'hc02] = d2;
    emit_imm2(op_ldis, 1, 16'h1000);
    emit_imm2(op_ldis, 7, 16'h1810);
    emit_regind(op_ld, 7, 2, 11'(-16));
    emit_regind(op_ld_l, 7, 3, 11'(-14));
    emit_regind(op_lda, 7, 4, 11'(-100));
    emit_regind(op_lda, 7, 5, 11'(1000));
    store_result(2, {16'h0000, d0});
    store_result(3, {d1, d2});
    store_result(4, 32'h1810 - 32'd100);
    store_result(5, 32'h1810 + 32'd1000);
    put(bad_insn);
    wait_halt();
    check_writes();
    end_test();
endtask

task automatic test_back_pressure();
    begin_test("back-pressure");
    reset_dut(1'b1);
    build_alu_program();
    wait_halt();
    check_writes();
    end_test();
endtask

task automatic test_fault();
    int n;
    begin_test("fault stop");
    reset_dut(1'b1);
    emit_inh(op_nop, 0, 0);
    put(bad_insn);
    repeat (4) emit_inh(op_nop, 0, 0);
    wait_halt();
    n = xa.size();
    repeat (50) step();  // observation window
    if (n != 2 || xa.size() != n) begin
        $display("%0d ns: bus transfers continued after the undecoded instruction", $time);
        errors++;
    end else begin
        check_addr("last fetch", xa[n - 1], 32'h0000_0002);
    end
    end_test();
endtask

/* test/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;
();

    localparam int    mem_words = 4096;
    localparam half_t bad_insn  = 16'h8400;  // unused inh opcode 20

    logic  clk;
    logic  rst_n;
    logic  bus_valid;
    logic  bus_ready;
    addr_t bus_addr;
    logic  bus_write;
    half_t bus_wdata;
    half_t bus_rdata;
    ccr_t  ccr;

    half_t       mem [mem_words];
    logic [15:0] lfsr;
    logic        zero_delay;
    int          delay;
    addr_t       held_addr;
    half_t       held_wdata;
    logic        held_write;

    // every completed transfer in bus order
    addr_t xa [$];
    logic  xw [$];
    half_t xd [$];

    addr_t exp_wa [$];
    half_t exp_wd [$];

    int    at;      // assembly cursor, byte address
    int    n_res;
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    test_base;
    string test_name;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    cpu_top #(.reset_pc(32'h0000_0000)) u_dut (
        .clk, .rst_n,
        .bus_valid, .bus_ready, .bus_addr, .bus_write, .bus_wdata, .bus_rdata,
        .ccr
    );

    function automatic logic next_lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // x^16+x^14+x^13+x^11+1
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int draw_delay();
        logic [1:0] d;
        d[1] = next_lfsr_bit();
        d[0] = next_lfsr_bit();
        return int'(d);
    endfunction

    // memory side of the bus at each falling edge
    task automatic mem_cycle();
        int idx;
        if (!rst_n || bus_ready) begin
            bus_ready = 1'b0;  // handshake took place at the last rising edge
            delay     = -1;
        end else if (bus_valid) begin
            idx = int'(bus_addr[12:1]);
            if (delay < 0) begin
                delay      = zero_delay ? 0 : draw_delay();
                held_addr  = bus_addr;
                held_wdata = bus_wdata;
                held_write = bus_write;
            end else begin
                check_addr("address held", bus_addr, held_addr);
                check_half("write data held", bus_wdata, held_wdata);
                check_half("write flag held", half_t'(bus_write), half_t'(held_write));
            end
            if (delay == 0) begin
                bus_ready = 1'b1;
                xa.push_back(bus_addr);
                xw.push_back(bus_write);
                if (bus_write)
                    mem[idx] = bus_wdata;
                else
                    bus_rdata = mem[idx];
                xd.push_back(bus_write ? bus_wdata : mem[idx]);
            end else begin
                delay--;
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        mem_cycle();
    endtask

    task automatic reset_dut(bit random_ready);
        step();
        rst_n      = 1'b0;
        zero_delay = !random_ready;
        xa.delete();
        xw.delete();
        xd.delete();
        exp_wa.delete();
        exp_wd.delete();
        for (int i = 0; i < mem_words; i++)
            mem[i] = half_t'(i) ^ 16'h3c5a;
        at    = 0;
        n_res = 0;
        repeat (5) begin
            step();
            check_half("bus_valid in reset", half_t'(bus_valid), 16'h0000);
            check_ccr("ccr in reset", ccr, 4'h0);
        end
        rst_n = 1'b1;
    endtask

    // halted once the bus has been idle for a while
    task automatic wait_halt();
        int idle;
        int cycles;
        idle   = 0;
        cycles = 0;
        while (idle < 16 && cycles < 4000) begin
            step();
            idle = bus_valid ? 0 : idle + 1;
            cycles++;
        end
        if (idle < 16) begin
            $display("timeout: the core was still using the bus after %0d cycles", cycles);
            errors++;
        end
    endtask

    task automatic put(half_t h);
        mem[at >> 1] = h;
        at += 2;
    endtask

    task automatic emit_inh(opcode_t op, reg_idx_t rb, reg_idx_t ra);
        put({3'b100, op[7:5], rb, ra});
    endtask

    task automatic emit_imm2(opcode_t op, reg_idx_t ra, half_t imm);
        put({3'b101, op, ra});
        put(imm);
    endtask

    task automatic emit_regind(opcode_t op, reg_idx_t rb, reg_idx_t ra, logic [10:0] disp);
        put({3'b010, op[7:5], rb, ra});
        put({op[4:0], disp});
    endtask

    task automatic emit_reg(alu_func_t f, reg_idx_t rb, reg_idx_t rc, reg_idx_t ra);
        put({3'b011, 3'b000, rb, ra});
        put({1'b0, f, 6'b000000, rc});
    endtask

    task automatic emit_imm3(alu_func_t f, reg_idx_t rb, reg_idx_t ra, half_t imm);
        put({3'b001, 3'b000, rb, ra});
        put({1'b0, f, 11'h000});
        put(imm);
    endtask

    task automatic emit_ldi(reg_idx_t ra, word_t v);
        put({3'b111, op_ldi, ra});
        put(v[31:16]);
        put(v[15:0]);
    endtask

    // st.l of one result to the next slot above r1
    task automatic store_result(reg_idx_t r, word_t value);
        addr_t a;
        a = 32'h1000 + 4 * n_res;
        emit_regind(op_st_l, 1, r, 11'(4 * n_res));
        exp_wa.push_back(a);
        exp_wd.push_back(value[31:16]);
        exp_wa.push_back(a + half_step);
        exp_wd.push_back(value[15:0]);
        n_res++;
    endtask

    function automatic word_t alu_model(alu_func_t f, word_t a, word_t b);
        case (f)
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_xor: return a ^ b;
            alu_shl: return a << b[4:0];
            alu_shr: return a >> b[4:0];
            default: return word_t'($signed(a) >>> b[4:0]);
        endcase
    endfunction

    function automatic ccr_t sub_flags(word_t a, word_t b);
        word_t d;
        d = a - b;
        return {a < b, d[31], (a[31] != b[31]) && (d[31] != a[31]), d == 32'd0};
    endfunction

    // branch outcome straight from the compared operands
    function automatic logic branch_expect(opcode_t op, word_t a, word_t b);
        case (op)
            op_bra:  return 1'b1;
            op_beq:  return a == b;
            op_bne:  return a != b;
            op_bgtu: return a > b;
            op_bgt:  return $signed(a) > $signed(b);
            op_bge:  return $signed(a) >= $signed(b);
            op_ble:  return $signed(a) <= $signed(b);
            op_blt:  return $signed(a) < $signed(b);
            op_bgeu: return a >= b;
            op_bltu: return a < b;
            op_bleu: return a <= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic build_alu_program();
        word_t a;
        word_t b;
        a = 32'h8765_4321;
        b = 32'hffff_ff85;  // shift amount 5
        emit_imm2(op_ldis, 1, 16'h1000);
        emit_ldi(2, a);
        emit_imm2(op_ldis, 3, 16'hff85);
        store_result(3, b);
        for (int f = 0; f < 8; f++) begin
            emit_reg(alu_func_t'(f), 2, 3, 4);
            store_result(4, alu_model(alu_func_t'(f), a, b));
        end
        for (int f = 0; f < 8; f++) begin
            emit_imm3(alu_func_t'(f), 2, 4, 16'h8003);
            store_result(4, alu_model(alu_func_t'(f), a, 32'hffff_8003));
        end
        emit_inh(op_mov, 2, 5);
        store_result(5, a);
        emit_inh(op_inc, 0, 5);
        store_result(5, a + 32'd1);
        emit_inh(op_dec, 0, 5);
        emit_inh(op_dec, 0, 5);
        store_result(5, a - 32'd1);
        put(bad_insn);
    endtask

    `include "tb_cpu_tests.svh"

    initial begin
        rst_n      = 1'b0;
        bus_ready  = 1'b0;
        bus_rdata  = '0;
        zero_delay = 1'b0;
        delay      = -1;
        lfsr       = 16'd61797;
        test_reset_fetch();
        test_alu_ops();
        test_cmp_branch();
        test_loads();
        test_back_pressure();
        test_fault();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;
#(
    parameter addr_t reset_pc = 32'hffc0_0000
) (
    input  logic  clk,
    input  logic  rst_n,
    output logic  bus_valid,
    input  logic  bus_ready,
    output addr_t bus_addr,
    output logic  bus_write,
    output half_t bus_wdata,
    input  half_t bus_rdata,
    output ccr_t  ccr
);

    logic       xfer_req;
    xfer_kind_t xfer_kind;
    addr_t      xfer_addr;
    half_t      xfer_wdata;
    logic       xfer_done;
    half_t      xfer_rdata;
    word_t      alu_a;
    word_t      alu_b;
    alu_func_t  alu_func;
    word_t      alu_y;
    ccr_t       alu_flags;
    reg_idx_t   rd_a;
    reg_idx_t   rd_b;
    word_t      rd_a_data;
    word_t      rd_b_data;
    logic       wr_en;
    reg_idx_t   wr_addr;
    word_t      wr_data;

    cpu_control #(.reset_pc(reset_pc)) u_control (
        .clk, .rst_n,
        .xfer_req, .xfer_kind, .xfer_addr, .xfer_wdata, .xfer_done, .xfer_rdata,
        .alu_a, .alu_b, .alu_func, .alu_y, .alu_flags,
        .rd_a, .rd_b, .rd_a_data, .rd_b_data,
        .wr_en, .wr_addr, .wr_data,
        .ccr
    );

    cpu_bus_unit u_bus_unit (
        .clk, .rst_n,
        .xfer_req, .xfer_kind, .xfer_addr, .xfer_wdata, .xfer_done, .xfer_rdata,
        .bus_valid, .bus_ready, .bus_addr, .bus_write, .bus_wdata, .bus_rdata
    );

    cpu_alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .func  (alu_func),
        .y     (alu_y),
        .flags (alu_flags)
    );

    cpu_regfile u_regfile (
        .clk, .rst_n,
        .rd_a, .rd_b, .rd_a_data, .rd_b_data,
        .wr_en, .wr_addr, .wr_data
    );

endmodule

/* source/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;
#(
    parameter addr_t reset_pc = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       rst_n,
    output logic       xfer_req,
    output xfer_kind_t xfer_kind,
    output addr_t      xfer_addr,
    output half_t      xfer_wdata,
    input  logic       xfer_done,
    input  half_t      xfer_rdata,
    output word_t      alu_a,
    output word_t      alu_b,
    output alu_func_t  alu_func,
    input  word_t      alu_y,
    input  ccr_t       alu_flags,
    output reg_idx_t   rd_a,
    output reg_idx_t   rd_b,
    input  word_t      rd_a_data,
    input  word_t      rd_b_data,
    output logic       wr_en,
    output reg_idx_t   wr_addr,
    output word_t      wr_data,
    output ccr_t       ccr
);

    typedef enum logic [3:0] {
        fetch1, eval1, fetch2, eval2, fetch3, eval3,
        load, load_low, store_low, fault
    } state_t;

    state_t  state;
    state_t  state_next;
    addr_t   pc;
    addr_t   pc_next;
    word_t   ir;
    word_t   ir_next;
    word_t   opnd;       // immediate, branch offset, load high half
    word_t   opnd_next;
    addr_t   mar;
    addr_t   mar_next;
    ccr_t    ccr_next;
    logic    issued;     // request out, waiting for done
    logic    taken;
    mode_t   mode;
    opcode_t op;

    assign mode = get_mode(ir);
    assign op   = get_opcode(ir);

    // reg mode reads rB and rC, everything else rA and rB
    assign rd_a    = (mode == mode_reg) ? field_rb(ir) : field_ra(ir);
    assign rd_b    = (mode == mode_reg) ? field_rc(ir) : field_rb(ir);
    assign wr_addr = field_ra(ir);

    always_comb begin
        case (op)
            op_bra:  taken = 1'b1;
            op_beq:  taken = ccr[flag_z];
            op_bne:  taken = !ccr[flag_z];
            op_bgtu: taken = !(ccr[flag_z] | ccr[flag_c]);
            op_bgt:  taken = !(ccr[flag_z] | (ccr[flag_n] ^ ccr[flag_v]));
            op_bge:  taken = !(ccr[flag_n] ^ ccr[flag_v]);
            op_ble:  taken = ccr[flag_z] | (ccr[flag_n] ^ ccr[flag_v]);
            op_blt:  taken = ccr[flag_n] ^ ccr[flag_v];
            op_bgeu: taken = !ccr[flag_c];
            op_bltu: taken = ccr[flag_c];
            op_bleu: taken = ccr[flag_c] | ccr[flag_z];
            default: taken = 1'b0; // brn
        endcase
    end

    always_comb begin
        state_next = state;
        pc_next    = pc;
        ir_next    = ir;
        opnd_next  = opnd;
        mar_next   = mar;
        ccr_next   = ccr;
        xfer_req   = 1'b0;
        xfer_kind  = xfer_fetch;
        xfer_addr  = pc;
        xfer_wdata = rd_a_data[15:0];
        alu_a      = rd_a_data;
        alu_b      = rd_b_data;
        alu_func   = alu_add;
        wr_en      = 1'b0;
        wr_data    = alu_y;

        case (state)
            fetch1, fetch2, fetch3: begin
                xfer_req = !issued;
                if (xfer_done) begin
                    pc_next = pc + half_step;
                    if (state == fetch1) begin
                        ir_next    = {xfer_rdata, 16'h0000};
                        state_next = eval1;
                    end else if (state == fetch2) begin
                        ir_next[15:0] = xfer_rdata;
                        opnd_next     = {{16{xfer_rdata[15]}}, xfer_rdata};
                        state_next    = eval2;
                    end else begin
                        opnd_next  = {opnd[15:0], xfer_rdata};
                        state_next = eval3;
                    end
                end
            end
            eval1: begin
                if (mode != mode_inh) begin
                    state_next = fetch2;
                end else begin
                    state_next = fetch1;
                    case (op)
                        op_nop: state_next = fetch1;
                        op_cmp: begin
                            alu_func = alu_sub;
                            ccr_next = alu_flags;
                        end
                        op_inc: begin
                            alu_b = 32'd1;
                            wr_en = 1'b1;
                        end
                        op_dec: begin
                            alu_func = alu_sub;
                            alu_b    = 32'd1;
                            wr_en    = 1'b1;
                        end
                        op_mov: begin
                            wr_data = rd_b_data;
                            wr_en   = 1'b1;
                        end
                        default: state_next = fault;
                    endcase
                end
            end
            eval2: begin
                state_next = fetch1;
                case (mode)
                    mode_imm2: begin
                        if (op == op_ldis) begin
                            wr_data = opnd;
                            wr_en   = 1'b1;
                        end else if (op <= op_brn) begin
                            if (taken)
                                pc_next = pc + opnd; // pc already past the offset
                        end else begin
                            state_next = fault;
                        end
                    end
                    mode_reg: begin
                        if (op[7:3] == 5'd0) begin
                            alu_func = alu_func_t'({1'b0, op[2:0]});
                            wr_en    = 1'b1;
                        end else begin
                            state_next = fault;
                        end
                    end
                    mode_regind: begin
                        alu_a    = rd_b_data;
                        alu_b    = {{21{ir[10]}}, ir[10:0]};
                        mar_next = alu_y;
                        case (op)
                            op_lda: wr_en = 1'b1;
                            op_ld, op_ld_l: state_next = load;
                            op_st, op_st_l: begin
                                // first store beat goes out from here
                                xfer_req   = !issued;
                                xfer_kind  = xfer_write;
                                xfer_addr  = alu_y;
                                xfer_wdata = (op == op_st_l) ? rd_a_data[31:16] : rd_a_data[15:0];
                                state_next = eval2;
                                if (xfer_done)
                                    state_next = (op == op_st_l) ? store_low : fetch1;
                            end
                            default: state_next = fault;
                        endcase
                    end
                    mode_imm3, mode_imm3a: state_next = fetch3;
                    default: state_next = fault;
                endcase
            end
            eval3: begin
                state_next = fetch1;
                if (mode == mode_imm3 && op[7:3] == 5'd0) begin
                    alu_a    = rd_b_data;
                    alu_b    = {{16{opnd[15]}}, opnd[15:0]};
                    alu_func = alu_func_t'({1'b0, op[2:0]});
                    wr_en    = 1'b1;
                end else if (mode == mode_imm3a && op == op_ldi) begin
                    wr_data = opnd;
                    wr_en   = 1'b1;
                end else begin
                    state_next = fault;
                end
            end
            load: begin
                xfer_req  = !issued;
                xfer_kind = xfer_read;
                xfer_addr = mar;
                if (xfer_done) begin
                    if (op == op_ld_l) begin
                        opnd_next  = {xfer_rdata, 16'h0000};
                        state_next = load_low;
                    end else begin
                        wr_data    = {16'h0000, xfer_rdata}; // zero extend
                        wr_en      = 1'b1;
                        state_next = fetch1;
                    end
                end
            end
            load_low: begin
                xfer_req  = !issued;
                xfer_kind = xfer_read;
                xfer_addr = mar + half_step;
                if (xfer_done) begin
                    wr_data    = {opnd[31:16], xfer_rdata};
                    wr_en      = 1'b1;
                    state_next = fetch1;
                end
            end
            store_low: begin
                xfer_req  = !issued;
                xfer_kind = xfer_write;
                xfer_addr = mar + half_step;
                if (xfer_done)
                    state_next = fetch1;
            end
            default: state_next = fault; // halted for good
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= fetch1;
            pc     <= reset_pc;
            ccr    <= '0;
            issued <= 1'b0;
        end else begin
            state  <= state_next;
            pc     <= pc_next;
            ccr    <= ccr_next;
            issued <= (issued | xfer_req) & !xfer_done;
        end
    end

    always_ff @(posedge clk) begin
        ir   <= ir_next;
        opnd <= opnd_next;
        mar  <= mar_next;
    end

endmodule

/* source/cpu_bus_unit.sv */
`timescale 1ns/1ps

module cpu_bus_unit
    import cpu_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       xfer_req,
    input  xfer_kind_t xfer_kind,
    input  addr_t      xfer_addr,
    input  half_t      xfer_wdata,
    output logic       xfer_done,
    output half_t      xfer_rdata,
    output logic       bus_valid,
    input  logic       bus_ready,
    output addr_t      bus_addr,
    output logic       bus_write,
    output half_t      bus_wdata,
    input  half_t      bus_rdata
);

    logic handshake;

    assign handshake = bus_valid && bus_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_valid <= 1'b0;
            bus_write <= 1'b0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= handshake; // one cycle pulse
            if (xfer_req) begin
                bus_valid <= 1'b1;
                bus_write <= (xfer_kind == xfer_write);
            end else if (handshake) begin
                bus_valid <= 1'b0;
                bus_write <= 1'b0;
            end
        end
    end

    // address and data held until the handshake
    always_ff @(posedge clk) begin
        if (xfer_req) begin
            bus_addr  <= xfer_addr;
            bus_wdata <= xfer_wdata;
        end
        if (handshake)
            xfer_rdata <= bus_rdata;
    end

endmodule

/* source/cpu_regfile.sv */
`timescale 1ns/1ps

module cpu_regfile
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_a,
    input  reg_idx_t rd_b,
    output word_t    rd_a_data,
    output word_t    rd_b_data,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data
);

    localparam int num_regs = 2 ** $bits(reg_idx_t);

    word_t regs [num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            regs <= '{default: '0};
        else if (wr_en)
            regs[wr_addr] <= wr_data;
    end

    assign rd_a_data = regs[rd_a]; // async read
    assign rd_b_data = regs[rd_b];

endmodule

/* source/cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;
(
    input  word_t     a,
    input  word_t     b,
    input  alu_func_t func,
    output word_t     y,
    output ccr_t      flags
);

    logic [32:0] sum;
    logic        carry;
    logic        ovf;

    always_comb begin
        sum   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (func)
            alu_and: y = a & b;
            alu_or:  y = a | b;
            alu_add: begin
                sum   = {1'b0, a} + {1'b0, b};
                y     = sum[31:0];
                carry = sum[32];
                ovf   = (a[31] == b[31]) && (y[31] != a[31]);
            end
            alu_sub: begin
                sum   = {1'b0, a} - {1'b0, b};
                y     = sum[31:0];
                carry = sum[32]; // borrow
                ovf   = (a[31] != b[31]) && (y[31] != a[31]);
            end
            alu_xor: y = a ^ b;
            alu_shl: y = a << b[4:0];
            alu_shr: y = a >> b[4:0];
            alu_sar: y = word_t'($signed(a) >>> b[4:0]);
            default: y = '0;
        endcase

        flags         = '0;
        flags[flag_c] = carry;
        flags[flag_n] = y[31];
        flags[flag_v] = ovf;
        flags[flag_z] = (y == '0);
    end

endmodule

/* source/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    typedef logic [4:0] reg_idx_t;
    typedef logic [7:0] opcode_t;

    localparam reg_idx_t stack_reg = 5'd31;

    typedef enum logic [2:0] {
        mode_inh2   = 3'd0,
        mode_imm3   = 3'd1,
        mode_regind = 3'd2,
        mode_reg    = 3'd3,
        mode_inh    = 3'd4,
        mode_imm2   = 3'd5,
        mode_imm3a  = 3'd7
    } mode_t;

    typedef enum logic [3:0] {
        alu_and = 4'd0,
        alu_or  = 4'd1,
        alu_add = 4'd2,
        alu_sub = 4'd3,
        alu_xor = 4'd4,
        alu_shl = 4'd5,
        alu_shr = 4'd6,
        alu_sar = 4'd7
    } alu_func_t;

    localparam int flag_c = 3;
    localparam int flag_n = 2;
    localparam int flag_v = 1;
    localparam int flag_z = 0;

    localparam opcode_t op_nop  = 8'h00; // inh
    localparam opcode_t op_cmp  = 8'h40;
    localparam opcode_t op_inc  = 8'h60;
    localparam opcode_t op_dec  = 8'h80;
    localparam opcode_t op_mov  = 8'he0;

    localparam opcode_t op_bra  = 8'h00; // imm2
    localparam opcode_t op_beq  = 8'h01;
    localparam opcode_t op_bne  = 8'h02;
    localparam opcode_t op_bgtu = 8'h03;
    localparam opcode_t op_bgt  = 8'h04;
    localparam opcode_t op_bge  = 8'h05;
    localparam opcode_t op_ble  = 8'h06;
    localparam opcode_t op_blt  = 8'h07;
    localparam opcode_t op_bgeu = 8'h08;
    localparam opcode_t op_bltu = 8'h09;
    localparam opcode_t op_bleu = 8'h0a;
    localparam opcode_t op_brn  = 8'h0b;
    localparam opcode_t op_ldis = 8'h10;

    localparam opcode_t op_st_l = 8'h00; // regind
    localparam opcode_t op_ld_l = 8'h01;
    localparam opcode_t op_st   = 8'h02;
    localparam opcode_t op_ld   = 8'h03;
    localparam opcode_t op_lda  = 8'h0a;

    localparam opcode_t op_ldi  = 8'h00; // imm3a

    function automatic mode_t get_mode(logic [31:0] ir);
        return mode_t'(ir[31:29]);
    endfunction

    function automatic opcode_t get_opcode(logic [31:0] ir);
        if (!ir[31])
            return {ir[28:26], ir[15:11]};
        else if (ir[31:29] == mode_inh)
            return {ir[28:26], 5'b00000};
        else
            return ir[28:21];
    endfunction

    function automatic reg_idx_t field_ra(logic [31:0] ir);
        return ir[20:16];
    endfunction

    function automatic reg_idx_t field_rb(logic [31:0] ir);
        return ir[25:21];
    endfunction

    function automatic reg_idx_t field_rc(logic [31:0] ir);
        return ir[4:0];
    endfunction

endpackage

/* source/cpu_bus_pkg.sv */
package cpu_bus_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [15:0] half_t;   // one bus beat
    typedef logic [31:0] word_t;   // register width

    // carry, negative, overflow, zero from msb down
    typedef logic [3:0] ccr_t;

    typedef enum logic [1:0] {
        xfer_fetch = 2'd0,
        xfer_read  = 2'd1,
        xfer_write = 2'd2
    } xfer_kind_t;

    localparam addr_t half_step = 32'd2; // bytes per halfword

endpackage
